// ==== vlog.f ====
+incdir+source
source/memPkg.sv
source/memArbiter.sv
source/busDriver.sv
source/byteGather.sv
source/byteRam.sv
source/memSubsystem.sv
test/memTb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= memTb
FILELIST   ?= vlog.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= test passed
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides the result, tee hides the simulator status
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== test/memTb.sv ====
`include "mem_config.svh"

module memTb import memPkg::*; ();
    localparam integer RandomPairs = 40;
    // roughly 30 cycles per access, random pairs plus the directed accesses
    localparam integer TimeoutCycles = 30 * (2 * RandomPairs + 20);

    logic    clk = 1'b0;
    logic    rst;
    logic    fetchReq;
    addrT    fetchAddr;
    logic    fetchDone;
    wordT    fetchInst;
    logic    dataReq;
    dataReqT dataReqInfo;
    logic    dataDone;
    wordT    dataRdata;
    logic    ioFull;

    byteT   refMem [0:(1 << `MEM_RAM_BITS) - 1];
    integer errorCount = 0;
    integer cycleCount = 0;
    integer reqCount = 0;
    integer seed = 32'h6911_7086;
    logic   fetchCredit;
    logic   dataCredit;

    memSubsystem DUT (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            $display("timeout after %0d cycles, a done pulse never arrived", cycleCount);
            $display("test failed");
            $finish;
        end
    end

    task automatic checkWord(input string name, input wordT got, input wordT exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            errorCount++;
        end
    endtask

    task automatic checkCycles(input string name, input integer got, input integer exp);
        if (got != exp) begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            errorCount++;
        end
    endtask

    // a done pulse needs an outstanding request on its own port
    task automatic checkStrayDone;
        if (fetchDone && fetchCredit) begin
            $display("fetchDone pulsed with no fetch request outstanding");
            errorCount++;
        end
        if (dataDone && dataCredit) begin
            $display("dataDone pulsed with no data request outstanding");
            errorCount++;
        end
    endtask

    // little endian, zero-extended, low RAM bits wrap
    function automatic wordT refRead(input addrT addr, input integer n);
        wordT   w;
        addrT   a;
        integer k;
        w = '0;
        for (k = 0; k < n; k++) begin
            a = addr + addrT'(k);
            w[8*k +: 8] = refMem[a[`MEM_RAM_BITS-1:0]];
        end
        return w;
    endfunction

    task automatic refWrite(input addrT addr, input wordT wdata, input integer n);
        addrT   a;
        integer k;
        for (k = 0; k < n; k++) begin
            a = addr + addrT'(k);
            refMem[a[`MEM_RAM_BITS-1:0]] = wdata[8*k +: 8];
        end
    endtask

    task automatic nextCycle;
        @(posedge clk);
        #1;
    endtask

    // spends the data credit, fields stay put until dataDone
    task automatic requestData(input addrT addr, input wordT wdata, input integer n,
                               input logic store);
        dataCredit = 1'b0;
        dataReqInfo.addr = addr;
        dataReqInfo.wdata = wdata;
        dataReqInfo.len = lenT'(n);
        dataReqInfo.store = store;
        dataReq = 1'b1;
    endtask

    task automatic requestFetch(input addrT addr);
        fetchCredit = 1'b0;
        fetchAddr = addr;
        fetchReq = 1'b1;
    endtask

    // request sampled on this edge, latency counts from here
    task automatic sendRequests;
        nextCycle;
        reqCount = cycleCount;
        fetchReq = 1'b0;
        dataReq = 1'b0;
    endtask

    task automatic waitData(output wordT result, output integer latency);
        @(negedge clk);
        checkStrayDone;
        while (!dataDone) begin
            @(negedge clk);
            checkStrayDone;
        end
        latency = cycleCount - reqCount;
        result = dataRdata;
        dataCredit = 1'b1;
    endtask

    task automatic waitFetch(output wordT result, output integer latency);
        @(negedge clk);
        checkStrayDone;
        while (!fetchDone) begin
            @(negedge clk);
            checkStrayDone;
        end
        latency = cycleCount - reqCount;
        result = fetchInst;
        fetchCredit = 1'b1;
    endtask

    task automatic doStore(input addrT addr, input wordT wdata, input integer n);
        wordT   result;
        integer latency;
        nextCycle;
        requestData(addr, wdata, n, 1'b1);
        sendRequests;
        waitData(result, latency);
        refWrite(addr, wdata, n);
        checkCycles("store latency", latency, n);
    endtask

    task automatic doLoad(input addrT addr, input integer n);
        wordT   result;
        integer latency;
        nextCycle;
        requestData(addr, 32'h0, n, 1'b0);
        sendRequests;
        waitData(result, latency);
        checkWord("dataRdata", result, refRead(addr, n));
        checkCycles("load latency", latency, n + 1);
    endtask

    task automatic doFetch(input addrT addr);
        wordT   result;
        integer latency;
        nextCycle;
        requestFetch(addr);
        sendRequests;
        waitFetch(result, latency);
        checkWord("fetchInst", result, refRead(addr, 4));
        checkCycles("fetch latency", latency, 5);
    endtask

    task automatic testIdle;
        integer k;
        for (k = 0; k < 20; k++) begin
            @(negedge clk);
            if (fetchDone || dataDone) begin
                $display("done pulse seen while no request was pending");
                errorCount++;
            end
        end
    endtask

    task automatic testStoreFetch;
        doStore(17'h00100, 32'h1234_5678, 4);
        doFetch(17'h00100);
    endtask

    // upper store bytes must not reach the RAM
    task automatic testMerge;
        doStore(17'h00203, 32'h6666_66c3, 1);
        doStore(17'h00202, 32'h5555_55a1, 1);
        doStore(17'h00200, 32'hdead_beef, 2);
        doLoad(17'h00200, 4);
        doLoad(17'h00201, 1);
        doLoad(17'h00202, 2);
    endtask

    task automatic testCollision;
        wordT   dataWord;
        wordT   fetchWord;
        integer dataLat;
        integer fetchLat;
        nextCycle;
        requestData(17'h00200, 32'h0, 4, 1'b0);
        requestFetch(17'h00100);
        sendRequests;
        waitData(dataWord, dataLat);
        waitFetch(fetchWord, fetchLat);
        checkWord("dataRdata", dataWord, refRead(17'h00200, 4));
        checkCycles("data latency", dataLat, 5);
        checkWord("fetchInst", fetchWord, refRead(17'h00100, 4));
        // data load, one FINISH cycle, then a whole fetch
        checkCycles("fetch latency", fetchLat, 5 + 1 + 5);
    endtask

    task automatic testStall;
        wordT   result;
        integer latency;
        integer k;
        for (k = 1; k <= 3; k += 2) begin
            nextCycle;
            requestData(17'h00200, 32'h0, 4, 1'b0);
            sendRequests;
            // stall from the second byte on
            nextCycle;
            nextCycle;
            ioFull = 1'b1;
            repeat (k) begin
                nextCycle;
            end
            ioFull = 1'b0;
            waitData(result, latency);
            checkWord("dataRdata", result, refRead(17'h00200, 4));
            checkCycles("stalled load latency", latency, 5 + k);
        end
    endtask

    task automatic testRandom;
        logic [31:0] r;
        wordT        wdata;
        addrT        addr;
        integer      n;
        integer      i;
        for (i = 0; i < RandomPairs; i++) begin
            r = $random(seed);
            wdata = $random(seed);
            case (i % 4)
                0: addr = 17'h1fffc + addrT'(r[1:0]);
                1: addr = {r[16:12], 10'h3ff, r[1:0]};
                default: addr = r[16:0];
            endcase
            n = (r[21:20] == 2'd0) ? 1 : ((r[21:20] == 2'd1) ? 2 : 4);
            doStore(addr, wdata, n);
            doLoad(addr, n);
        end
    endtask

    initial begin
        rst = 1'b1;
        fetchReq = 1'b0;
        fetchAddr = '0;
        dataReq = 1'b0;
        dataReqInfo = '0;
        ioFull = 1'b0;
        fetchCredit = 1'b1;
        dataCredit = 1'b1;
        repeat (10) begin
            @(posedge clk);
        end
        #1;
        rst = 1'b0;
        testIdle;
        testStoreFetch;
        testMerge;
        testCollision;
        testStall;
        testRandom;
        $display("%0d errors after %0d cycles", errorCount, cycleCount);
        if (errorCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== source/memSubsystem.sv ====
`include "mem_config.svh"

module memSubsystem import memPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    fetchReq,
    input  addrT    fetchAddr,
    output logic    fetchDone,
    output wordT    fetchInst,
    input  logic    dataReq,
    input  dataReqT dataReqInfo,
    output logic    dataDone,
    output wordT    dataRdata,
    input  logic    ioFull
);
    portSelT grant;
    logic    start;
    logic    active;
    logic    stall;
    stepT    step;
    memBusT  memBus;
    byteT    rdata;
    wordT    word;
    lenT     gatherLen;

    memArbiter arbiter (
        .clk(clk),
        .rst(rst),
        .fetchReq(fetchReq),
        .dataReq(dataReq),
        .dataLen(dataReqInfo.len),
        .dataStore(dataReqInfo.store),
        .ioFull(ioFull),
        .grant(grant),
        .start(start),
        .active(active),
        .stall(stall),
        .step(step),
        .fetchDone(fetchDone),
        .dataDone(dataDone)
    );

    busDriver driver (
        .clk(clk),
        .rst(rst),
        .start(start),
        .active(active),
        .stall(stall),
        .step(step),
        .grant(grant),
        .fetchAddr(fetchAddr),
        .dataReqInfo(dataReqInfo),
        .memBus(memBus)
    );

    // fetches always gather a full word
    assign gatherLen = (grant == `MEM_PORT_DATA) ? dataReqInfo.len : `MEM_FETCH_LEN;

    byteGather gather (
        .clk(clk),
        .rst(rst),
        .start(start),
        .active(active),
        .stall(stall),
        .step(step),
        .rdata(rdata),
        .len(gatherLen),
        .word(word)
    );

    byteRam ram (
        .clk(clk),
        .memBus(memBus),
        .rdata(rdata)
    );

    assign fetchInst = fetchDone ? word : '0;
    assign dataRdata = dataDone ? word : '0;

endmodule

// ==== source/byteRam.sv ====
`include "mem_config.svh"

module byteRam import memPkg::*; (
    input  logic   clk,
    input  memBusT memBus,
    output byteT   rdata
);
    byteT mem [0:(1 << `MEM_RAM_BITS) - 1];
    logic [`MEM_RAM_BITS-1:0] index;

    // high address bits wrap
    assign index = memBus.addr[`MEM_RAM_BITS-1:0];

    always_ff @(posedge clk) begin
        if (memBus.write) begin
            mem[index] <= memBus.wdata;
        end
        rdata <= mem[index];
    end

endmodule

// ==== source/byteGather.sv ====
module byteGather import memPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic active,
    input  logic stall,
    input  stepT step,
    input  byteT rdata,
    input  lenT  len,
    output wordT word
);
    wordT wordQ;
    wordT merged;
    wordT laneMask;
    lenT  lenQ;
    stepT stepQ;
    logic readQ;

    // RAM answers one cycle after the address
    always_ff @(posedge clk) begin
        if (rst) begin
            readQ <= 1'b0;
        end else begin
            readQ <= active && !stall;
        end
    end

    always_ff @(posedge clk) begin
        stepQ <= step;
        if (start) begin
            lenQ <= len;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            wordQ <= '0;
        end else if (readQ) begin
            wordQ <= merged;
        end
    end

    // last byte is used straight from the RAM
    always_comb begin
        merged = wordQ;
        if (readQ) begin
            merged[{stepQ, 3'b000} +: 8] = rdata;
        end
    end

    always_comb begin
        case (lenQ)
            3'd1: laneMask = 32'h0000_00ff;
            3'd2: laneMask = 32'h0000_ffff;
            default: laneMask = 32'hffff_ffff;
        endcase
    end

    // zero extension
    assign word = merged & laneMask;

endmodule

// ==== source/busDriver.sv ====
`include "mem_config.svh"

module busDriver import memPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    start,
    input  logic    active,
    input  logic    stall,
    input  stepT    step,
    input  portSelT grant,
    input  addrT    fetchAddr,
    input  dataReqT dataReqInfo,
    output memBusT  memBus
);
    addrT baseQ;
    wordT wdataQ;
    logic storeQ;

    always_ff @(posedge clk) begin
        if (rst) begin
            storeQ <= 1'b0;
        end else if (start) begin
            storeQ <= (grant == `MEM_PORT_DATA) && dataReqInfo.store;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            baseQ <= (grant == `MEM_PORT_DATA) ? dataReqInfo.addr : fetchAddr;
            wdataQ <= dataReqInfo.wdata;
        end
    end

    // little endian, byte k of the word at base+k
    always_comb begin
        memBus.addr = baseQ + addrT'(step);
        memBus.wdata = wdataQ[{step, 3'b000} +: 8];
        memBus.write = active && !stall && storeQ;
    end

endmodule

// ==== source/memArbiter.sv ====
`include "mem_config.svh"

module memArbiter import memPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    fetchReq,
    input  logic    dataReq,
    input  lenT     dataLen,
    input  logic    dataStore,
    input  logic    ioFull,
    output portSelT grant,
    output logic    start,
    output logic    active,
    output logic    stall,
    output stepT    step,
    output logic    fetchDone,
    output logic    dataDone
);
    ctrlStateT state;
    portSelT   grantQ;
    portSelT   pick;
    stepT      lastStep;
    logic      storeQ;
    logic      fetchPend;
    logic      dataPend;
    logic      lastCycle;

    // data port wins a tie
    assign pick = dataPend ? `MEM_PORT_DATA : `MEM_PORT_FETCH;

    assign grant = (state == IDLE) ? pick : grantQ;
    assign start = (state == IDLE) && !ioFull && (fetchPend || dataPend);
    assign active = (state == ACCESS);
    assign stall = ioFull;

    // final byte goes out this cycle
    assign lastCycle = active && !ioFull && (step == lastStep);

    // a store is done with its last write, a load once its last byte is back
    assign fetchDone = (state == FINISH) && (grantQ == `MEM_PORT_FETCH);
    assign dataDone = (grantQ == `MEM_PORT_DATA) &&
                      (storeQ ? lastCycle : (state == FINISH));

    // one request flag per port, kept until the port is granted
    always_ff @(posedge clk) begin
        if (rst) begin
            fetchPend <= 1'b0;
            dataPend <= 1'b0;
        end else begin
            fetchPend <= fetchReq ||
                         (fetchPend && !(start && pick == `MEM_PORT_FETCH));
            dataPend <= dataReq ||
                        (dataPend && !(start && pick == `MEM_PORT_DATA));
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            grantQ <= `MEM_PORT_FETCH;
            step <= '0;
            lastStep <= '0;
            storeQ <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= ACCESS;
                        grantQ <= pick;
                        step <= '0;
                        if (pick == `MEM_PORT_DATA) begin
                            lastStep <= stepT'(dataLen - 3'd1);
                            storeQ <= dataStore;
                        end else begin
                            lastStep <= stepT'(`MEM_FETCH_LEN - 3'd1);
                            storeQ <= 1'b0;
                        end
                    end
                end
                ACCESS: begin
                    // a full I/O buffer freezes the step
                    if (!ioFull) begin
                        if (step == lastStep) begin
                            state <= FINISH;
                        end else begin
                            step <= step + 2'd1;
                        end
                    end
                end
                FINISH: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

// ==== source/memPkg.sv ====
`include "mem_config.svh"

package memPkg;

    // byte address
    typedef logic [`MEM_ADDR_WIDTH-1:0] addrT;

    // instruction or data word
    typedef logic [31:0] wordT;

    // one RAM byte
    typedef logic [7:0] byteT;

    // access length in bytes, 1, 2 or 4
    typedef logic [2:0] lenT;

    // byte index within an access
    typedef logic [1:0] stepT;

    // 0 is fetch, 1 is data
    typedef logic [0:0] portSelT;

    // data port request, held stable until dataDone
    typedef struct packed {
        addrT addr;
        wordT wdata;
        lenT  len;
        logic store;
    } dataReqT;

    // one byte-wide RAM cycle
    typedef struct packed {
        addrT addr;
        byteT wdata;
        logic write;
    } memBusT;

    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        FINISH
    } ctrlStateT;

endpackage

// ==== source/mem_config.svh ====
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// byte address width seen by the requesters
`define MEM_ADDR_WIDTH 17

// implemented RAM address bits, upper address bits wrap
`define MEM_RAM_BITS 12

// a fetch always moves one full word
`define MEM_FETCH_LEN 3'd4

// port numbering for the grant
`define MEM_PORT_FETCH 1'b0
`define MEM_PORT_DATA 1'b1

`endif
